//--- hdl/uartPkg.sv
// frame constants and payload types shared by the serial port RTL and its testbench
package uartPkg;

	////////////////////////////////////////////////////////////
	// frame format
	////////////////////////////////////////////////////////////

	// one start bit, dataBits data bits lsb first, one stop bit
	localparam int dataBits   = 8;	// data bits per frame
	localparam int overSample = 16;	// ticks per bit period
	localparam int stopTicks  = 16;	// ticks in the stop bit, 16 for one stop bit

	////////////////////////////////////////////////////////////
	// payloads
	////////////////////////////////////////////////////////////

	// plain byte, tx fifo payload and rx shift data
	typedef logic [dataBits-1:0] dataWord_t;

	// rx fifo payload, 9 bits
	typedef struct packed {
		logic      frameErr;	// stop bit sampled low
		dataWord_t data;	// received byte
	} rxWord_t;

	////////////////////////////////////////////////////////////
	// rx and tx FSM states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		stIdle,		// line high, waiting
		stStart,	// start bit
		stData,		// data bits
		stStop		// stop bit
	} uartState_t;

endpackage

//--- hdl/baudTickGen.sv
// oversampling tick timer, pulses sTick once every clkPerTick clocks for both directions
`timescale 1ns/10ps

module baudTickGen #(
	parameter int clkPerTick = 4	// clocks per tick, 2 or more
) (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	localparam int cntWidth = $clog2(clkPerTick);
	localparam logic [cntWidth-1:0] reloadVal = cntWidth'(clkPerTick - 1);

	logic [cntWidth-1:0] cnt;	// down-counter

	// first tick lands clkPerTick clocks after reset drops
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt   <= reloadVal;
			sTick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt   <= reloadVal;	// reload
			sTick <= 1'b1;		// and tick on the same edge
		end
		else
		begin
			cnt   <= cnt - 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

//--- hdl/uartRx.sv
// 16x oversampling receiver, turns rx frames into a byte plus framing flag and a done pulse
`timescale 1ns/10ps

module uartRx (
	input  logic             clk,
	input  logic             reset,
	input  logic             sTick,
	input  logic             rx,
	output logic             rxDoneTick,
	output uartPkg::rxWord_t rxWord
);
	import uartPkg::*;

	localparam int tickWidth = $clog2(stopTicks > overSample ? stopTicks : overSample);
	localparam int bitWidth  = $clog2(dataBits);
	localparam logic [tickWidth-1:0] midStart = tickWidth'(overSample / 2 - 1);
	localparam logic [tickWidth-1:0] lastTick = tickWidth'(overSample - 1);
	localparam logic [tickWidth-1:0] lastStop = tickWidth'(stopTicks - 1);
	localparam logic [bitWidth-1:0]  lastBit  = bitWidth'(dataBits - 1);

	uartState_t           stateReg, stateNext;
	logic [tickWidth-1:0] sReg, sNext;	// tick counter
	logic [bitWidth-1:0]  nReg, nNext;	// bit counter
	dataWord_t            bReg, bNext;	// shift register
	logic                 errReg, errNext;	// stop bit seen low
	logic                 doneNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg   <= stIdle;
			sReg       <= '0;
			nReg       <= '0;
			rxDoneTick <= 1'b0;
		end
		else
		begin
			stateReg   <= stateNext;
			sReg       <= sNext;
			nReg       <= nNext;
			rxDoneTick <= doneNext;
		end
	end

	// shift data and flag, word held from done until next frame ends
	always_ff @(posedge clk)
	begin
		bReg   <= bNext;
		errReg <= errNext;
		if (doneNext)
			rxWord <= '{frameErr: errNext, data: bReg};
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		errNext   = errReg;
		doneNext  = 1'b0;
		case (stateReg)
			stIdle:
				if (!rx)	// falling edge of start bit
				begin
					stateNext = stStart;
					sNext     = '0;
				end
			stStart:
				if (sTick)
				begin
					if (sReg == midStart)	// middle of start bit
					begin
						stateNext = stData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			stData:
				if (sTick)
				begin
					if (sReg == lastTick)	// middle of next data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[dataBits-1:1]};	// lsb first
						if (nReg == lastBit)
							stateNext = stStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stStop:
				if (sTick)
				begin
					if (sReg == lastTick)
						errNext = !rx;	// mid stop bit, must be high
					if (sReg == lastStop)
					begin
						stateNext = stIdle;
						doneNext  = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = stIdle;
		endcase
	end

endmodule

//--- hdl/uartTx.sv
// transmitter FSM, pops bytes from the tx FIFO and shifts them out on tx at the tick rate
`timescale 1ns/10ps

module uartTx (
	input  logic               clk,
	input  logic               reset,
	input  logic               sTick,
	input  logic               txEmpty,
	input  uartPkg::dataWord_t txByte,
	output logic               txPop,
	output logic               tx
);
	import uartPkg::*;

	localparam int tickWidth = $clog2(stopTicks > overSample ? stopTicks : overSample);
	localparam int bitWidth  = $clog2(dataBits);
	localparam logic [tickWidth-1:0] lastTick = tickWidth'(overSample - 1);
	localparam logic [tickWidth-1:0] lastStop = tickWidth'(stopTicks - 1);
	localparam logic [bitWidth-1:0]  lastBit  = bitWidth'(dataBits - 1);

	uartState_t           stateReg, stateNext;
	logic [tickWidth-1:0] sReg, sNext;	// ticks within bit
	logic [bitWidth-1:0]  nReg, nNext;	// data bits sent
	dataWord_t            bReg, bNext;	// outgoing byte
	logic                 txNext;
	logic                 takeByte;	// start a frame with fifo head

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg     <= '0;
			nReg     <= '0;
			tx       <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			tx       <= txNext;	// registered, glitch free
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		txNext    = tx;
		takeByte  = 1'b0;
		case (stateReg)
			stIdle:
				takeByte = sTick && !txEmpty;	// align start bit to a tick
			stStart:
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						stateNext = stData;
						sNext     = '0;
						nNext     = '0;
						txNext    = bReg[0];	// first data bit
					end
					else
						sNext = sReg + 1'b1;
				end
			stData:
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext  = '0;
						bNext  = {1'b0, bReg[dataBits-1:1]};
						txNext = bNext[0];
						if (nReg == lastBit)
						begin
							stateNext = stStop;
							txNext    = 1'b1;	// stop bit
						end
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stStop:
				if (sTick)
				begin
					if (sReg == lastStop)
					begin
						stateNext = stIdle;
						takeByte  = !txEmpty;	// next byte right away, no gap
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = stIdle;
		endcase
		// load the head byte and drop the line for the start bit
		if (takeByte)
		begin
			stateNext = stStart;
			sNext     = '0;
			bNext     = txByte;
			txNext    = 1'b0;
		end
		txPop = takeByte;
	end

endmodule

//--- hdl/uartFifo.sv
// show-ahead synchronous FIFO, payload type set per instance, used for rx and tx queues
`timescale 1ns/10ps

module uartFifo #(
	parameter type payload_t = logic [7:0],	// entry type
	parameter int  fifoDepth = 8		// entries, power of two
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     write,
	input  payload_t writeData,
	input  logic     read,
	output payload_t readData,
	output logic     empty,
	output logic     full
);

	localparam int addrWidth = $clog2(fifoDepth);

	payload_t           mem [fifoDepth];	// storage, no reset
	logic [addrWidth:0] wrPtr;	// extra msb tells wrap
	logic [addrWidth:0] rdPtr;
	logic               doWrite;
	logic               doRead;

	////////////////////////////////////////////////////////////
	// flags and head
	////////////////////////////////////////////////////////////

	assign empty = (wrPtr == rdPtr);
	// same slot, different lap
	assign full  = (wrPtr[addrWidth] != rdPtr[addrWidth]) &&
	               (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);

	assign doWrite = write && !full;	// dropped when full
	assign doRead  = read && !empty;	// ignored when empty

	assign readData = mem[rdPtr[addrWidth-1:0]];	// head shown ahead of read

	////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr[addrWidth-1:0]] <= writeData;
	end

	// read and write may land in the same cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
		end
	end

endmodule

//--- hdl/uartCore.sv
// serial port top level, tick timer plus receiver and transmitter each with its own FIFO
`timescale 1ns/10ps

module uartCore #(
	parameter int clkPerTick = 4,	// clocks per 16x tick
	parameter int fifoDepth  = 8	// entries per FIFO
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               rx,
	output logic               tx,
	input  uartPkg::dataWord_t txData,
	input  logic               txWrite,
	output logic               txFull,
	output uartPkg::dataWord_t rxData,
	output logic               rxFrameErr,
	input  logic               rxRead,
	output logic               rxEmpty
);
	import uartPkg::*;

	logic      sTick;		// shared timebase
	logic      rxDoneTick;	// rx word ready, fifo write
	rxWord_t   rxWord;
	rxWord_t   rxHead;		// head of rx fifo
	logic      txPop;
	logic      txEmpty;
	dataWord_t txHead;		// head of tx fifo

	baudTickGen #(
		.clkPerTick(clkPerTick)
	) u_baudTickGen (
		.clk  (clk),
		.reset(reset),
		.sTick(sTick)
	);

	////////////////////////////////////////////////////////////
	// receive path
	////////////////////////////////////////////////////////////

	uartRx u_uartRx (
		.clk       (clk),
		.reset     (reset),
		.sTick     (sTick),
		.rx        (rx),
		.rxDoneTick(rxDoneTick),
		.rxWord    (rxWord)
	);

	// full fifo drops the new word
	uartFifo #(
		.payload_t(rxWord_t),
		.fifoDepth(fifoDepth)
	) rxFifo (
		.clk      (clk),
		.reset    (reset),
		.write    (rxDoneTick),
		.writeData(rxWord),
		.read     (rxRead),
		.readData (rxHead),
		.empty    (rxEmpty),
		.full     ()
	);

	assign rxData     = rxHead.data;
	assign rxFrameErr = rxHead.frameErr;

	////////////////////////////////////////////////////////////
	// transmit path
	////////////////////////////////////////////////////////////

	uartFifo #(
		.payload_t(dataWord_t),
		.fifoDepth(fifoDepth)
	) txFifo (
		.clk      (clk),
		.reset    (reset),
		.write    (txWrite),
		.writeData(txData),
		.read     (txPop),
		.readData (txHead),
		.empty    (txEmpty),
		.full     (txFull)
	);

	uartTx u_uartTx (
		.clk    (clk),
		.reset  (reset),
		.sTick  (sTick),
		.txEmpty(txEmpty),
		.txByte (txHead),
		.txPop  (txPop),
		.tx     (tx)
	);

endmodule

//--- dv/uartCoreTb.sv
// testbench for the serial port core, drives rx frames, decodes tx and checks the rx FIFO words
`timescale 1ns/10ps

module uartCoreTb;
	import uartPkg::*;

	localparam int clkPerTick  = 4;
	localparam int fifoDepth   = 8;
	localparam int drvDelay    = 2;	// ns after rising edge
	localparam int bitCycles   = clkPerTick * overSample;	// 64 clocks per bit
	localparam int frameCycles = bitCycles * (dataBits + 2);	// 640
	localparam int breakGap    = 12 * bitCycles;	// idle line after a low stop bit
	// about 48 frames over all tests, rounded up to 62
	localparam int maxCycles   = 62 * frameCycles;
	localparam logic [5:0] stopPattern = 6'b101101;	// framing test, bit 0 first

	logic      clk;
	logic      reset;
	logic      rxDrive;	// serial driver
	logic      loopback;	// rx fed from tx
	logic      rxLine;
	logic      tx;
	dataWord_t txData;
	logic      txWrite;
	logic      txFull;
	dataWord_t rxData;
	logic      rxFrameErr;
	logic      rxRead;
	logic      rxEmpty;

	rxWord_t     expQ[$];	// expected rx words, in order
	dataWord_t   txExpQ[$];	// bytes written to tx FIFO
	logic [31:0] rngState   = 32'h9938_dc33;
	string       testName   = "none";
	int          checkCount = 0;
	int          errCount   = 0;
	int          popCount   = 0;
	int          testCount  = 0;
	int          testChecks = 0;	// counts at test start
	int          testErrs   = 0;
	int          cycleCount = 0;

	assign rxLine = loopback ? tx : rxDrive;

	uartCore #(
		.clkPerTick(clkPerTick),
		.fifoDepth (fifoDepth)
	) u_uartCore (
		.clk       (clk),
		.reset     (reset),
		.rx        (rxLine),
		.tx        (tx),
		.txData    (txData),
		.txWrite   (txWrite),
		.txFull    (txFull),
		.rxData    (rxData),
		.rxFrameErr(rxFrameErr),
		.rxRead    (rxRead),
		.rxEmpty   (rxEmpty)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	////////////////////////////////////////////////////////////
	// reference and random bytes
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic dataWord_t nextByte();
		rngState = xorshift32(rngState);
		return rngState[7:0];
	endfunction

	// byte comes back as sent, frameErr only when the stop bit went out low
	function automatic rxWord_t expectedWord(input dataWord_t b, input logic stopBit);
		rxWord_t w;
		w.data     = b;
		w.frameErr = !stopBit;
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// checks and bookkeeping
	////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errCount++;
			$display("** Error %s: %s expected %0h, actual %0h", testName, what, expected, actual);
		end
	endtask

	task automatic checkTrue(input logic cond, input string msg);
		checkCount++;
		assert (cond)
		else
		begin
			errCount++;
			$display("error in test %s: %s", testName, msg);
		end
	endtask

	task automatic startTest(input string name);
		testName   = name;
		testChecks = checkCount;
		testErrs   = errCount;
	endtask

	task automatic endTest();
		testCount++;
		$display("test %s: %0d checks, %0d errors", testName,
			checkCount - testChecks, errCount - testErrs);
	endtask

	////////////////////////////////////////////////////////////
	// drivers and monitor
	////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge clk);
		#drvDelay;	// inputs change just after the edge
	endtask

	// one frame on rx, start bit first then lsb first
	task automatic sendFrame(input dataWord_t b, input logic stopBit);
		logic [dataBits+1:0] bits;
		bits = {stopBit, b, 1'b0};
		for (int i = 0; i < dataBits + 2; i++)
		begin
			rxDrive = bits[i];
			repeat (bitCycles) nextCycle();
		end
		rxDrive = 1'b1;	// idle
	endtask

	task automatic sendAndExpect(input dataWord_t b, input logic stopBit);
		sendFrame(b, stopBit);
		expQ.push_back(expectedWord(b, stopBit));
		if (!stopBit)
		begin
			// receiver rearms mid stop bit while the line is still low, so that reads as
			// a start bit; with the line idle after it the frame is all ones, stop high
			repeat (breakGap) nextCycle();
			expQ.push_back(expectedWord(8'hff, 1'b1));
		end
	endtask

	// decode one tx frame, sampled at bit centers on falling clock
	task automatic readFrame(output dataWord_t b, output logic stopBit);
		@(negedge clk);
		while (tx !== 1'b0)
			@(negedge clk);
		repeat (bitCycles / 2) @(negedge clk);
		checkTrue(tx === 1'b0, "tx start bit not low at its center");
		for (int i = 0; i < dataBits; i++)
		begin
			repeat (bitCycles) @(negedge clk);
			b[i] = tx;
		end
		repeat (bitCycles) @(negedge clk);
		stopBit = tx;
	endtask

	task automatic writeTx(input dataWord_t b);
		txData  = b;
		txWrite = 1'b1;
		nextCycle();
		txWrite = 1'b0;
	endtask

	task automatic drainRx();
		while (!rxEmpty)
		begin
			rxRead = 1'b1;
			nextCycle();
		end
		rxRead = 1'b0;
	endtask

	task automatic popOne();
		while (rxEmpty)
			nextCycle();
		rxRead = 1'b1;
		nextCycle();
		rxRead = 1'b0;
	endtask

	// every popped word against the head of the expected queue
	task automatic compareRx();
		rxWord_t expected;
		forever
		begin
			@(negedge clk);	// head and read strobe both settled
			if (rxRead && !rxEmpty)
			begin
				popCount++;
				if (expQ.size() == 0)
					checkTrue(1'b0, "rx FIFO gave a word that no test expected");
				else
				begin
					expected = expQ.pop_front();
					checkValue("rx word", 32'(expected), 32'({rxFrameErr, rxData}));
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// watchdog and test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		while (cycleCount < maxCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: no result after %0d cycles", maxCycles);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		dataWord_t wb;
		dataWord_t rb;
		dataWord_t eb;
		logic      rs;
		int        popBase;
		reset    = 1'b1;
		rxDrive  = 1'b1;
		loopback = 1'b0;
		txData   = '0;
		txWrite  = 1'b0;
		rxRead   = 1'b0;
		fork
			compareRx();
		join_none
		repeat (16) @(posedge clk);
		#drvDelay;
		reset = 1'b0;

		startTest("reset");
		nextCycle();
		checkValue("tx", 32'(1), 32'(tx));
		checkValue("rxEmpty", 32'(1), 32'(rxEmpty));
		checkValue("txFull", 32'(0), 32'(txFull));
		endTest();

		// first byte leaves the FIFO at once, fifoDepth + 1 writes fill it
		startTest("transmit");
		fork
			begin
				for (int i = 0; i < fifoDepth + 1; i++)
				begin
					wb = nextByte();
					txExpQ.push_back(wb);
					writeTx(wb);
					if (i == 5)
						checkValue("txFull after six writes", 32'(0), 32'(txFull));
				end
				checkValue("txFull with fifoDepth unsent", 32'(1), 32'(txFull));
			end
			begin
				for (int i = 0; i < fifoDepth + 1; i++)
				begin
					readFrame(rb, rs);
					eb = txExpQ.pop_front();
					checkValue("tx byte", 32'(eb), 32'(rb));
					checkValue("tx stop bit", 32'(1), 32'(rs));
				end
			end
		join
		endTest();

		startTest("receive");
		for (int i = 0; i < 8; i++)
			sendAndExpect(nextByte(), 1'b1);
		drainRx();
		checkValue("words left unread", 32'(0), 32'(expQ.size()));
		endTest();

		startTest("framing");
		for (int i = 0; i < 6; i++)
			sendAndExpect(nextByte(), stopPattern[i]);
		drainRx();
		checkValue("words left unread", 32'(0), 32'(expQ.size()));
		endTest();

		// only the first fifoDepth words fit, later ones are dropped
		startTest("overflow");
		popBase = popCount;
		for (int i = 0; i < fifoDepth + 3; i++)
		begin
			wb = nextByte();
			sendFrame(wb, 1'b1);
			if (i < fifoDepth)
				expQ.push_back(expectedWord(wb, 1'b1));
		end
		drainRx();
		checkValue("words read", 32'(fifoDepth), 32'(popCount - popBase));
		checkValue("words left unread", 32'(0), 32'(expQ.size()));
		endTest();

		startTest("loopback");
		loopback = 1'b1;
		fork
			begin
				for (int i = 0; i < 10; i++)
				begin
					while (txFull)
						nextCycle();
					wb = nextByte();
					expQ.push_back(expectedWord(wb, 1'b1));
					writeTx(wb);
				end
			end
			begin
				for (int i = 0; i < 10; i++)
					popOne();
			end
		join
		loopback = 1'b0;
		// no extra word behind the ten sent
		checkValue("rxEmpty after ten reads", 32'(1), 32'(rxEmpty));
		endTest();

		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- build.f
hdl/uartPkg.sv
hdl/baudTickGen.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/uartFifo.sv
hdl/uartCore.sv
dv/uartCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the serial port testbench with Verilator, run it, decide from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--timescale 1ns/10ps \
	--top-module uartCoreTb \
	-f build.f \
	-o uartCoreSim

./obj_dir/uartCoreSim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "run passed"
else
	echo "run failed"
	exit 1
fi
